// File: Makefile
sim:
	verilator --binary --timing --assert --top-module tb_rv_core -f verilog.f -o sim_rv
	./obj_dir/sim_rv | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: rv_alu.sv
`timescale 1ns/10ps

module rv_alu import rv_pkg::*; (
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  input  alu_op_e         op,
  output logic [xlen-1:0] result,
  output logic            zero
);

  // shift amount from low five bits of b
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      // compare results are a single bit, zero extended
      alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      // arithmetic shift keeps the sign of a
      alu_sra:    result = $signed(a) >>> shamt;
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      default:    result = a + b;
    endcase
  end

  // feeds beq/bne decision in the core
  assign zero = (result == '0);

endmodule

// File: rv_control.sv
`timescale 1ns/10ps

module rv_control import rv_pkg::*; (
  input  logic [xlen-1:0] instr,
  output ctrl_t           ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       bit30;
  alu_op_e    arith_op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign bit30  = instr[30];

  // alu op for r-type and i-type arithmetic
  always_comb begin
    case (funct3)
      // sub only exists in the register form
      3'b000:  arith_op = (opcode == op_rtype && bit30) ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      // sra vs srl for both reg and shift-immediate
      3'b101:  arith_op = bit30 ? alu_sra : alu_srl;
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  end

  // main decoder
  always_comb begin
    // defaults act as a no-op
    ctrl             = '0;
    ctrl.src_a       = src_a_reg;
    ctrl.wb_sel      = wb_alu;
    ctrl.alu_op      = alu_add;
    case (opcode)
      op_rtype: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = arith_op;
      end
      op_itype: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = arith_op;
      end
      op_load: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.wb_sel      = wb_mem;
      end
      op_store: begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
      end
      // compare by subtraction, core looks at zero
      op_branch: begin
        ctrl.branch = 1'b1;
        ctrl.alu_op = alu_sub;
      end
      // 0 + imm
      op_lui: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.src_a       = src_a_zero;
      end
      op_auipc: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.src_a       = src_a_pc;
      end
      // link value is pc + 4
      op_jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.wb_sel    = wb_pc4;
      end
      default: ;
    endcase
  end

endmodule

// File: rv_core.sv
`timescale 1ns/10ps

module rv_core import rv_pkg::*; (
  input  logic                  CLK,
  input  logic                  RESET_N,
  input  logic [xlen-1:0]       idata,
  output logic [addr_width-1:0] iaddr,
  output logic [addr_width-1:0] daddr,
  input  logic [xlen-1:0]       ddata_r,
  output logic [xlen-1:0]       ddata_w,
  output logic                  d_rw
);

  // byte address of current instruction
  logic [addr_width-1:0] pc;
  logic [addr_width-1:0] pc_plus4;
  logic [addr_width-1:0] br_target;
  logic [addr_width-1:0] pc_next;

  ctrl_t           ctrl;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_result;
  logic            alu_zero;
  logic [xlen-1:0] wb_data;
  logic [2:0]      funct3;
  logic            br_cond;
  logic            taken;

  assign funct3 = idata[14:12];

  rv_control i_control (
    .instr (idata),
    .ctrl  (ctrl)
  );

  rv_imm_gen i_imm_gen (
    .instr (idata),
    .imm   (imm)
  );

  // register indices straight from the instruction fields
  rv_regfile i_regfile (
    .CLK     (CLK),
    .RESET_N (RESET_N),
    .rs1     (idata[19:15]),
    .rs2     (idata[24:20]),
    .rd      (idata[11:7]),
    .wdata   (wb_data),
    .we      (ctrl.reg_write),
    .rdata1  (rdata1),
    .rdata2  (rdata2)
  );

  // operand a, pc zero extended for auipc
  always_comb begin
    case (ctrl.src_a)
      src_a_pc:   op_a = {{(xlen-addr_width){1'b0}}, pc};
      src_a_zero: op_a = '0;
      default:    op_a = rdata1;
    endcase
  end

  assign op_b = ctrl.alu_src_imm ? imm : rdata2;

  rv_alu i_alu (
    .a      (op_a),
    .b      (op_b),
    .op     (ctrl.alu_op),
    .result (alu_result),
    .zero   (alu_zero)
  );

  // write-back select
  always_comb begin
    case (ctrl.wb_sel)
      wb_mem:  wb_data = ddata_r;
      wb_pc4:  wb_data = {{(xlen-addr_width){1'b0}}, pc_plus4};
      default: wb_data = alu_result;
    endcase
  end

  // both adders wrap within addr_width
  assign pc_plus4  = pc + addr_width'(4);
  assign br_target = pc + imm[addr_width-1:0];

  // bne taken on non-zero difference, beq on zero
  assign br_cond = (funct3 == 3'b001) ? !alu_zero : alu_zero;
  assign taken   = ctrl.jump | (ctrl.branch & br_cond);
  assign pc_next = taken ? br_target : pc_plus4;

  always_ff @(posedge CLK or negedge RESET_N) begin
    if (!RESET_N) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // word indices for both memories
  assign iaddr   = {2'b00, pc[addr_width-1:2]};
  assign daddr   = alu_result[addr_width+1:2];
  assign ddata_w = rdata2;
  assign d_rw    = ctrl.mem_write;

endmodule

// File: rv_imm_gen.sv
`timescale 1ns/10ps

module rv_imm_gen import rv_pkg::*; (
  input  logic [xlen-1:0] instr,
  output logic [xlen-1:0] imm
);

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  // all formats sign extend from instr[31]
  assign imm_i = {{21{instr[31]}}, instr[30:20]};
  assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
  // b and j are halfword offsets, bit 0 always clear
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  // format picked by opcode
  always_comb begin
    case (instr[6:0])
      op_store:          imm = imm_s;
      op_branch:         imm = imm_b;
      op_lui, op_auipc:  imm = imm_u;
      op_jal:            imm = imm_j;
      // itype and load, also harmless for rtype
      default:           imm = imm_i;
    endcase
  end

endmodule

// File: rv_pkg.sv
package rv_pkg;

  // datapath widths
  localparam int xlen       = 32;
  localparam int addr_width = 10;
  localparam int reg_addr_w = 5;

  // major opcodes, instr[6:0]
  localparam logic [6:0] op_rtype  = 7'b0110011;
  localparam logic [6:0] op_itype  = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;

  // alu operations
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    // forwards operand b unchanged
    alu_pass_b = 4'd10
  } alu_op_e;

  // operand a source
  typedef enum logic [1:0] {
    src_a_reg  = 2'd0,
    src_a_pc   = 2'd1,
    src_a_zero = 2'd2
  } src_a_e;

  // write-back source
  typedef enum logic [1:0] {
    wb_alu = 2'd0,
    wb_mem = 2'd1,
    wb_pc4 = 2'd2
  } wb_sel_e;

  // decoded control levels for one instruction
  typedef struct packed {
    logic    reg_write;
    logic    mem_write;
    logic    branch;
    logic    jump;
    logic    alu_src_imm;
    src_a_e  src_a;
    wb_sel_e wb_sel;
    alu_op_e alu_op;
  } ctrl_t;

endpackage

// File: rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile import rv_pkg::*; (
  input  logic                  CLK,
  input  logic                  RESET_N,
  input  logic [reg_addr_w-1:0] rs1,
  input  logic [reg_addr_w-1:0] rs2,
  input  logic [reg_addr_w-1:0] rd,
  input  logic [xlen-1:0]       wdata,
  input  logic                  we,
  output logic [xlen-1:0]       rdata1,
  output logic [xlen-1:0]       rdata2
);

  logic [xlen-1:0] regs [2**reg_addr_w];

  // write on rising edge, x0 never written
  always_ff @(posedge CLK or negedge RESET_N) begin
    if (!RESET_N) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // combinational reads
  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

endmodule

// File: tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core import rv_pkg::*; ();

  logic                  CLK;
  logic                  RESET_N;
  logic [xlen-1:0]       idata;
  logic [addr_width-1:0] iaddr;
  logic [addr_width-1:0] daddr;
  logic [xlen-1:0]       ddata_r;
  logic [xlen-1:0]       ddata_w;
  logic                  d_rw;

  // program rom, data ram and golden copies
  logic [31:0] rom [256];
  logic [31:0] ram [1024];
  logic [31:0] exp_ram [1024];
  logic [31:0] gregs [32];
  // word index expected per executed cycle
  logic [9:0]  exp_iaddr [$];
  // store log with one entry per sw
  logic [9:0]  st_addr [$];
  logic [31:0] st_data [$];
  string       st_name [$];
  logic [31:0] lfsr_state = 32'hdcd1a674;
  int          pc_w = 0;
  int          st_ptr = 0;
  int          seq_idx = 0;
  int          st_idx = 0;
  int          cycles = 0;
  int          max_cycles = 0;

  rv_core i_dut (
    .CLK     (CLK),
    .RESET_N (RESET_N),
    .idata   (idata),
    .iaddr   (iaddr),
    .daddr   (daddr),
    .ddata_r (ddata_r),
    .ddata_w (ddata_w),
    .d_rw    (d_rw)
  );

  // both memories answer within the cycle
  assign idata   = rom[iaddr[7:0]];
  assign ddata_r = ram[daddr];

  always @(posedge CLK) begin
    if (d_rw) ram[daddr] <= ddata_w;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    stop_on_error($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
  endtask

  // galois lfsr for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
    end
    return v;
  endfunction

  // instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_rtype};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // rv32i arithmetic where alt picks sub or sra
  function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic emit(input logic [31:0] w);
    rom[pc_w] = w;
    exp_iaddr.push_back(10'(pc_w));
    pc_w++;
  endtask

  // skipped word holding a store absent from the log
  task automatic place_trap();
    rom[pc_w] = enc_s(12'h7fc, 5'd1, 5'd0);
    pc_w++;
  endtask

  task automatic put_reg(input logic [4:0] rd, input logic [31:0] v);
    if (rd != 5'd0) gregs[rd] = v;
  endtask

  // lui rounds up so addi's signed low part lands exactly
  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    emit(enc_u(hi[31:12], rd, op_lui));
    emit(enc_i(v[11:0], rd, 3'd0, rd, op_itype));
    put_reg(rd, v);
  endtask

  task automatic store_reg(input string name, input logic [4:0] rs);
    emit(enc_s(12'(st_ptr * 4), rs, 5'd0));
    st_addr.push_back(10'(st_ptr));
    st_data.push_back(gregs[rs]);
    st_name.push_back(name);
    exp_ram[st_ptr] = gregs[rs];
    st_ptr++;
  endtask

  // x3 = x1 op x2
  task automatic r_op_store(input string name, input logic [2:0] f3, input logic alt);
    emit(enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
    put_reg(5'd3, model_alu(f3, alt, gregs[1], gregs[2]));
    store_reg(name, 5'd3);
  endtask

  // x3 = x1 op imm
  task automatic i_op_store(input string name, input logic [2:0] f3, input logic [11:0] imm);
    emit(enc_i(imm, 5'd1, f3, 5'd3, op_itype));
    put_reg(5'd3, model_alu(f3, f3 == 3'd5 && imm[10], gregs[1], {{20{imm[11]}}, imm}));
    store_reg(name, 5'd3);
  endtask

  // forward by two words with a trap in between when taken
  task automatic branch_fwd(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    logic taken;
    taken = (gregs[rs1] == gregs[rs2]) ^ (f3 == 3'b001);
    emit(enc_b(13'd8, rs2, rs1, f3));
    if (taken) place_trap();
  endtask

  task automatic build_program();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] t;
    // word 0 is a nop so d_rw stays low out of reset
    emit(enc_i(12'd0, 5'd0, 3'd0, 5'd0, op_itype));
    for (int k = 0; k < 3; k++) begin
      load_const(5'd1, rand_bits(32));
      store_reg("lui+addi", 5'd1);
    end
    for (int k = 0; k < 2; k++) begin
      t = rand_bits(20);
      emit(enc_u(t[19:0], 5'd2, op_auipc));
      put_reg(5'd2, 32'(pc_w * 4 - 4) + {t[19:0], 12'h000});
      store_reg("auipc", 5'd2);
    end
    // round 0 has negative rs1 and round 1 negative rs2
    for (int r = 0; r < 2; r++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      a[31] = (r == 0);
      b[31] = (r != 0);
      load_const(5'd1, a);
      load_const(5'd2, b);
      r_op_store("add", 3'd0, 1'b0);
      r_op_store("sub", 3'd0, 1'b1);
      r_op_store("sll", 3'd1, 1'b0);
      r_op_store("slt", 3'd2, 1'b0);
      r_op_store("sltu", 3'd3, 1'b0);
      r_op_store("xor", 3'd4, 1'b0);
      r_op_store("srl", 3'd5, 1'b0);
      r_op_store("sra", 3'd5, 1'b1);
      r_op_store("or", 3'd6, 1'b0);
      r_op_store("and", 3'd7, 1'b0);
      t = rand_bits(12);
      t[11] = (r == 0);
      i_op_store("addi", 3'd0, t[11:0]);
      i_op_store("slti", 3'd2, t[11:0]);
      i_op_store("sltiu", 3'd3, t[11:0]);
      i_op_store("xori", 3'd4, t[11:0]);
      i_op_store("ori", 3'd6, t[11:0]);
      i_op_store("andi", 3'd7, t[11:0]);
      t = rand_bits(5);
      i_op_store("slli", 3'd1, {7'h00, t[4:0]});
      i_op_store("srli", 3'd5, {7'h00, t[4:0]});
      i_op_store("srai", 3'd5, {7'h20, t[4:0]});
    end
    // write to x0 is dropped
    emit(enc_i(12'h123, 5'd1, 3'd0, 5'd0, op_itype));
    store_reg("x0 write", 5'd0);
    // read back the first store and then an untouched word
    emit(enc_i(12'd0, 5'd0, 3'b010, 5'd3, op_load));
    put_reg(5'd3, exp_ram[0]);
    store_reg("lw round trip", 5'd3);
    emit(enc_i(12'd1200, 5'd0, 3'b010, 5'd3, op_load));
    put_reg(5'd3, exp_ram[300]);
    store_reg("lw preset word", 5'd3);
    a = rand_bits(32);
    load_const(5'd4, a);
    load_const(5'd5, a);
    load_const(5'd6, ~a);
    branch_fwd(3'b000, 5'd4, 5'd5);
    branch_fwd(3'b000, 5'd4, 5'd6);
    branch_fwd(3'b001, 5'd4, 5'd6);
    branch_fwd(3'b001, 5'd4, 5'd5);
    // jal over a trap with the link exposed by sw
    put_reg(5'd7, 32'(pc_w * 4 + 4));
    emit(enc_j(21'd8, 5'd7));
    place_trap();
    store_reg("jal link", 5'd7);
    // final jump to self marks the end
    emit(enc_j(21'd0, 5'd0));
  endtask

  task automatic check_store();
    assert (st_idx < st_addr.size())
      else stop_on_error("a store happened after the expected store log was used up");
    assert (daddr == st_addr[st_idx])
      else report_mismatch({st_name[st_idx], " addr"}, {22'd0, st_addr[st_idx]}, {22'd0, daddr});
    assert (ddata_w == st_data[st_idx])
      else report_mismatch(st_name[st_idx], st_data[st_idx], ddata_w);
    st_idx++;
  endtask

  task automatic finish_run();
    assert (st_idx == st_addr.size())
      else stop_on_error("the program ended before all expected stores were seen");
    for (int i = 0; i < 1024; i++) begin
      assert (ram[i] == exp_ram[i]) else report_mismatch("ram image", exp_ram[i], ram[i]);
    end
    $display("All tests passed!");
    $finish;
  endtask

  reset_iaddr_zero: assert property (@(posedge CLK) !RESET_N |-> iaddr == '0)
    else report_mismatch("reset iaddr", 32'd0, {22'd0, iaddr});

  // per-cycle sequence and store checks
  always @(posedge CLK) begin
    if (RESET_N) begin
      cycles++;
      if (cycles > max_cycles) stop_on_error("timeout, the final jump was never reached");
      assert (iaddr == exp_iaddr[seq_idx])
        else report_mismatch("pc sequence", {22'd0, exp_iaddr[seq_idx]}, {22'd0, iaddr});
      if (d_rw) check_store();
      if (seq_idx == exp_iaddr.size() - 1) finish_run();
      else seq_idx++;
    end
  end

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  initial begin
    RESET_N = 1'b0;
    // preset data distinct for every word index
    for (int i = 0; i < 1024; i++) begin
      ram[i] = {10'(i), ~10'(i), 10'(i) ^ 10'h2a5, 2'b01};
      exp_ram[i] = ram[i];
    end
    for (int i = 0; i < 32; i++) gregs[i] = '0;
    for (int i = 0; i < 256; i++) rom[i] = enc_i(12'd0, 5'd0, 3'd0, 5'd0, op_itype);
    build_program();
    max_cycles = 2 * pc_w + 20;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RESET_N = 1'b1;
  end

endmodule

// File: verilog.f
rv_pkg.sv
rv_alu.sv
rv_control.sv
rv_imm_gen.sv
rv_regfile.sv
rv_core.sv
tb_rv_core.sv
